// File: Makefile
SOURCES := $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/Vtb_obi_integrity
	./obj_dir/Vtb_obi_integrity | tee /dev/stderr | grep "^STATUS: PASS$$" > /dev/null

obj_dir/Vtb_obi_integrity: compile.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_obi_integrity -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
obi_integrity_pkg.sv
obi_request_port.sv
obi_txn_tracker.sv
obi_response_checker.sv
obi_integrity_ctrl.sv
obi_integrity_top.sv
obi_integrity_asserts.sv
tb_obi_integrity.sv

// File: obi_integrity_asserts.sv
// Parity and alert assertions

`timescale 1ns/100ps
`default_nettype none

module obi_integrity_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic obi_req_o,
  input logic obi_reqpar_o,
  input logic obi_gnt_i,
  input logic obi_gntpar_i,
  input logic obi_rvalid_i,
  input logic obi_rvalidpar_i,
  input logic alert_major_o
);

  int fail_count;

  initial fail_count = 0;

  reqpar_inverse: assert property (@(posedge clk_i) obi_reqpar_o == !obi_req_o)
    else begin
      fail_count++;
      $error("obi_reqpar_o is not the inverse of obi_req_o");
    end

  // A parity mismatch in one cycle must raise the alert in the next
  gnt_parity_alert: assert property (@(posedge clk_i) disable iff (reset_i)
    (obi_gnt_i == obi_gntpar_i) |=> alert_major_o)
    else begin
      fail_count++;
      $error("grant parity mismatch was not followed by an alert");
    end

  rvalid_parity_alert: assert property (@(posedge clk_i) disable iff (reset_i)
    (obi_rvalid_i == obi_rvalidpar_i) |=> alert_major_o)
    else begin
      fail_count++;
      $error("rvalid parity mismatch was not followed by an alert");
    end

endmodule

bind obi_integrity_top obi_integrity_asserts u_asserts (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .obi_req_o       (obi_req_o),
  .obi_reqpar_o    (obi_reqpar_o),
  .obi_gnt_i       (obi_gnt_i),
  .obi_gntpar_i    (obi_gntpar_i),
  .obi_rvalid_i    (obi_rvalid_i),
  .obi_rvalidpar_i (obi_rvalidpar_i),
  .alert_major_o   (alert_major_o)
);

`default_nettype wire

// File: obi_integrity_ctrl.sv
// Integrity enable, alert and fault cause

`timescale 1ns/100ps
`default_nettype none

module obi_integrity_ctrl (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            cfg_we_i,
  input  logic                            cfg_integrity_en_i,
  input  logic                            obi_gnt_i,
  input  logic                            obi_gntpar_i,
  input  logic                            obi_rvalid_i,
  input  logic                            obi_rvalidpar_i,
  input  logic                            core_resp_valid_i,
  input  obi_integrity_pkg::core_resp_t   core_resp_i,
  input  logic                            resp_is_store_i,
  output obi_integrity_pkg::txn_info_t    push_info_o,
  output logic                            rvalid_parity_err_o,
  output logic                            alert_major_o,
  output obi_integrity_pkg::fault_cause_e fault_cause_o
);

  import obi_integrity_pkg::*;

  logic         integrity_en_q;
  logic         gnt_par_err;
  logic         rvalid_par_err;
  logic         par_alert_q;
  logic         resp_fault;
  fault_cause_e fault_cause_q;

  // Each parity bit must be the complement of its signal in every cycle
  assign gnt_par_err    = (obi_gnt_i == obi_gntpar_i);
  assign rvalid_par_err = (obi_rvalid_i == obi_rvalidpar_i);

  assign rvalid_parity_err_o = rvalid_par_err;

  // The top level fills in the store flag from the bus payload
  always_comb begin
    push_info_o.is_store       = 1'b0;
    push_info_o.had_integrity  = integrity_en_q;
    push_info_o.gnt_parity_err = gnt_par_err;
  end

  assign resp_fault = core_resp_valid_i && core_resp_i.integrity_err;

  // Response faults arrive already registered, parity faults one cycle late
  assign alert_major_o = par_alert_q || resp_fault;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      integrity_en_q <= 1'b1;
      par_alert_q    <= 1'b0;
      fault_cause_q  <= FAULT_NONE;
    end else begin
      par_alert_q <= gnt_par_err || rvalid_par_err;
      if (cfg_we_i) begin
        integrity_en_q <= cfg_integrity_en_i;
      end
      // A config write clears the cause, otherwise the first fault sticks
      if (cfg_we_i) begin
        fault_cause_q <= FAULT_NONE;
      end else if (resp_fault && (fault_cause_q == FAULT_NONE)) begin
        fault_cause_q <= resp_is_store_i ? FAULT_STORE : FAULT_LOAD;
      end
    end
  end

  assign fault_cause_o = fault_cause_q;

endmodule

`default_nettype wire

// File: obi_integrity_pkg.sv
// OBI data bus integrity definitions

`default_nettype none

package obi_integrity_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ACHK_W = 12;
  localparam int RCHK_W = 5;

  // The exokay signal is not implemented on this bus
  localparam logic EXOKAY_TIE_OFF = 1'b0;

  // Request payload as it travels from the core to the bus
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [3:0]        be;
    logic              we;
    logic [2:0]        prot;
    logic [1:0]        memtype;
    logic              dbg;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
  } obi_resp_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              integrity_err;
  } core_resp_t;

  // One entry per granted transaction still waiting for its response
  typedef struct packed {
    logic is_store;
    logic had_integrity;
    logic gnt_parity_err;
  } txn_info_t;

  typedef enum logic [10:0] {
    FAULT_NONE  = 11'd0,
    FAULT_LOAD  = 11'd1026,
    FAULT_STORE = 11'd1027
  } fault_cause_e;

  // Control groups use odd parity, data and address bytes use even parity
  function automatic logic [ACHK_W-1:0] achk_compute(input obi_req_t req);
    return {^req.wdata[31:24], ^req.wdata[23:16], ^req.wdata[15:8], ^req.wdata[7:0],
            1'b0,
            ~^req.dbg,
            ~^{req.be, req.we},
            ~^{req.prot, req.memtype},
            ^req.addr[31:24], ^req.addr[23:16], ^req.addr[15:8], ^req.addr[7:0]};
  endfunction

  function automatic logic [RCHK_W-1:0] rchk_compute(input logic [DATA_W-1:0] rdata,
                                                      input logic err);
    return {^{err, EXOKAY_TIE_OFF},
            ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage

`default_nettype wire

// File: obi_integrity_top.sv
// OBI data bus integrity unit

`timescale 1ns/100ps
`default_nettype none

module obi_integrity_top #(
  parameter int OUTSTANDING_DEPTH = 2
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 core_req_valid_i,
  input  obi_integrity_pkg::obi_req_t          core_req_i,
  output logic                                 core_req_ready_o,
  output logic                                 obi_req_o,
  output logic                                 obi_reqpar_o,
  output obi_integrity_pkg::obi_req_t          obi_req_payload_o,
  output logic [obi_integrity_pkg::ACHK_W-1:0] obi_achk_o,
  input  logic                                 obi_gnt_i,
  input  logic                                 obi_gntpar_i,
  input  logic                                 obi_rvalid_i,
  input  logic                                 obi_rvalidpar_i,
  input  obi_integrity_pkg::obi_resp_t         obi_resp_i,
  output logic                                 core_resp_valid_o,
  output obi_integrity_pkg::core_resp_t        core_resp_o,
  input  logic                                 cfg_we_i,
  input  logic                                 cfg_integrity_en_i,
  output logic                                 alert_major_o,
  output obi_integrity_pkg::fault_cause_e      fault_cause_o
);

  import obi_integrity_pkg::*;

  logic      tracker_full;
  logic      push;
  txn_info_t ctrl_push_info;
  txn_info_t push_info;
  txn_info_t head;
  logic      rvalid_parity_err;
  logic      resp_is_store_q;

  assign push = obi_req_o && obi_gnt_i;

  always_comb begin
    push_info          = ctrl_push_info;
    push_info.is_store = obi_req_payload_o.we;
  end

  // Store flag follows the response through its register stage
  always_ff @(posedge clk_i) begin
    if (obi_rvalid_i) begin
      resp_is_store_q <= head.is_store;
    end
  end

  obi_request_port u_req_port (
    .clk_i, .reset_i, .core_req_valid_i, .core_req_i, .core_req_ready_o,
    .tracker_full_i (tracker_full),
    .obi_req_o, .obi_reqpar_o, .obi_req_payload_o, .obi_achk_o, .obi_gnt_i
  );

  obi_txn_tracker #(.OUTSTANDING_DEPTH(OUTSTANDING_DEPTH)) u_tracker (
    .clk_i, .reset_i,
    .push_i      (push),
    .push_info_i (push_info),
    .pop_i       (obi_rvalid_i),
    .full_o      (tracker_full),
    .head_o      (head)
  );

  obi_response_checker u_resp_checker (
    .clk_i, .reset_i, .obi_rvalid_i, .obi_resp_i,
    .head_i              (head),
    .rvalid_parity_err_i (rvalid_parity_err),
    .core_resp_valid_o, .core_resp_o
  );

  obi_integrity_ctrl u_ctrl (
    .clk_i, .reset_i, .cfg_we_i, .cfg_integrity_en_i,
    .obi_gnt_i, .obi_gntpar_i, .obi_rvalid_i, .obi_rvalidpar_i,
    .core_resp_valid_i   (core_resp_valid_o),
    .core_resp_i         (core_resp_o),
    .resp_is_store_i     (resp_is_store_q),
    .push_info_o         (ctrl_push_info),
    .rvalid_parity_err_o (rvalid_parity_err),
    .alert_major_o, .fault_cause_o
  );

endmodule

`default_nettype wire

// File: obi_request_port.sv
// OBI request port with checksum generation

`timescale 1ns/100ps
`default_nettype none

module obi_request_port (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 core_req_valid_i,
  input  obi_integrity_pkg::obi_req_t          core_req_i,
  output logic                                 core_req_ready_o,
  input  logic                                 tracker_full_i,
  output logic                                 obi_req_o,
  output logic                                 obi_reqpar_o,
  output obi_integrity_pkg::obi_req_t          obi_req_payload_o,
  output logic [obi_integrity_pkg::ACHK_W-1:0] obi_achk_o,
  input  logic                                 obi_gnt_i
);

  import obi_integrity_pkg::*;

  logic              req_q;
  obi_req_t          payload_q;
  logic [ACHK_W-1:0] achk_q;
  logic              accept;
  logic              granted;

  // Only one request is held at a time, and the tracker must have room for it
  assign core_req_ready_o = !req_q && !tracker_full_i;
  assign accept           = core_req_valid_i && core_req_ready_o;
  assign granted          = req_q && obi_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;
    end else if (granted) begin
      req_q <= 1'b0;
    end
  end

  // The checksum is computed from the core request so it is stable
  // for as long as the payload is held on the bus
  always_ff @(posedge clk_i) begin
    if (accept) begin
      payload_q <= core_req_i;
      achk_q    <= achk_compute(core_req_i);
    end
  end

  assign obi_req_o         = req_q;
  assign obi_reqpar_o      = ~req_q;
  assign obi_req_payload_o = payload_q;
  assign obi_achk_o        = achk_q;

endmodule

`default_nettype wire

// File: obi_response_checker.sv
// OBI response checksum checker

`timescale 1ns/100ps
`default_nettype none

module obi_response_checker (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          obi_rvalid_i,
  input  obi_integrity_pkg::obi_resp_t  obi_resp_i,
  input  obi_integrity_pkg::txn_info_t  head_i,
  input  logic                          rvalid_parity_err_i,
  output logic                          core_resp_valid_o,
  output obi_integrity_pkg::core_resp_t core_resp_o
);

  import obi_integrity_pkg::*;

  logic [RCHK_W-1:0] rchk_exp;
  logic              rchk_mismatch;
  logic              chk_err;
  core_resp_t        resp_d;
  core_resp_t        resp_q;
  logic              valid_q;

  always_comb begin
    rchk_exp = rchk_compute(obi_resp_i.rdata, obi_resp_i.err);
    // A store returns no read data, so only the err/exokay bit is meaningful
    if (head_i.is_store) begin
      rchk_mismatch = (rchk_exp[RCHK_W-1] != obi_resp_i.rchk[RCHK_W-1]);
    end else begin
      rchk_mismatch = (rchk_exp != obi_resp_i.rchk);
    end
  end

  // Checksum faults only count for requests issued with integrity enabled
  assign chk_err = head_i.had_integrity && rchk_mismatch;

  always_comb begin
    resp_d.rdata         = obi_resp_i.rdata;
    resp_d.err           = obi_resp_i.err;
    resp_d.integrity_err = chk_err || rvalid_parity_err_i || head_i.gnt_parity_err;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= obi_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_rvalid_i) begin
      resp_q <= resp_d;
    end
  end

  assign core_resp_valid_o = valid_q;
  assign core_resp_o       = resp_q;

endmodule

`default_nettype wire

// File: obi_txn_tracker.sv
// Outstanding transaction queue

`timescale 1ns/100ps
`default_nettype none

module obi_txn_tracker #(
  parameter int OUTSTANDING_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         push_i,
  input  obi_integrity_pkg::txn_info_t push_info_i,
  input  logic                         pop_i,
  output logic                         full_o,
  output obi_integrity_pkg::txn_info_t head_o
);

  import obi_integrity_pkg::*;

  localparam int PTR_W = (OUTSTANDING_DEPTH > 1) ? $clog2(OUTSTANDING_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUTSTANDING_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(OUTSTANDING_DEPTH - 1);

  txn_info_t        entries_q [OUTSTANDING_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
  endfunction

  assign do_pop  = pop_i && (count_q != '0);
  // A full queue can still take a push when the head leaves in the same cycle
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entries_q[wr_ptr_q] <= push_info_i;
    end
  end

  assign full_o = (count_q == CNT_W'(OUTSTANDING_DEPTH));

  // Responses return in order, so the oldest entry belongs to the next one
  assign head_o = entries_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: tb_obi_integrity.sv
// Testbench for the OBI integrity unit

`timescale 1ns/100ps
`default_nettype none

module tb_obi_integrity;

  import obi_integrity_pkg::*;

  localparam int DEPTH          = 2;
  localparam int REQ_WAIT_LIMIT = 100;
  localparam int PHASE_LIMIT    = 6000;

  logic              clk;
  logic              reset;
  logic              core_req_valid;
  obi_req_t          core_req;
  logic              core_req_ready;
  logic              obi_req;
  logic              obi_reqpar;
  obi_req_t          obi_req_payload;
  logic [ACHK_W-1:0] obi_achk;
  logic              obi_gnt;
  logic              obi_gntpar;
  logic              obi_rvalid;
  logic              obi_rvalidpar;
  obi_resp_t         obi_resp;
  logic              core_resp_valid;
  core_resp_t        core_resp;
  logic              cfg_we;
  logic              cfg_integrity_en;
  logic              alert_major;
  fault_cause_e      fault_cause;

  // Reference model state
  logic [31:0]  lcg_state;
  int           cycle;
  int           reqs_left;
  int           req_wait;
  int           error_count;
  int           timeouts;
  int           faults_seen;
  logic         req_done;
  logic         cfg_pending;
  logic         cfg_value;
  logic         model_en;
  fault_cause_e model_cause;
  obi_req_t     acc_q[$];
  txn_info_t    pend_q[$];
  int           pend_ready_q[$];
  logic         cur_rvalid;
  logic         cur_store;
  core_resp_t   cur_resp;
  logic         exp_valid;
  logic         exp_store;
  core_resp_t   exp_resp;
  logic         exp_alert;

  obi_integrity_top #(.OUTSTANDING_DEPTH(DEPTH)) dut0 (
    .clk_i (clk), .reset_i (reset),
    .core_req_valid_i (core_req_valid), .core_req_i (core_req),
    .core_req_ready_o (core_req_ready),
    .obi_req_o (obi_req), .obi_reqpar_o (obi_reqpar),
    .obi_req_payload_o (obi_req_payload), .obi_achk_o (obi_achk),
    .obi_gnt_i (obi_gnt), .obi_gntpar_i (obi_gntpar),
    .obi_rvalid_i (obi_rvalid), .obi_rvalidpar_i (obi_rvalidpar), .obi_resp_i (obi_resp),
    .core_resp_valid_o (core_resp_valid), .core_resp_o (core_resp),
    .cfg_we_i (cfg_we), .cfg_integrity_en_i (cfg_integrity_en),
    .alert_major_o (alert_major), .fault_cause_o (fault_cause)
  );

  always #20 clk = ~clk;

  // The low LCG bits have short periods, so the high half is folded in
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  function automatic logic chance(input int unsigned one_in);
    return (next_random() % one_in) == 0;
  endfunction

  function automatic obi_req_t random_request();
    obi_req_t    r;
    logic [31:0] ctrl;
    r.addr    = next_random();
    r.wdata   = next_random();
    ctrl      = next_random();
    r.be      = ctrl[3:0];
    r.we      = ctrl[4];
    r.prot    = ctrl[7:5];
    r.memtype = ctrl[9:8];
    r.dbg     = ctrl[10];
    return r;
  endfunction

  // Request checksum built bit by bit from counts of set bits
  function automatic logic [ACHK_W-1:0] expected_achk(input obi_req_t req);
    logic [ACHK_W-1:0] chk;
    chk = '0;
    for (int i = 0; i < 4; i++) begin
      chk[8 + i] = ($countones(req.wdata[8*i +: 8]) % 2) == 1;
      chk[i]     = ($countones(req.addr[8*i +: 8]) % 2) == 1;
    end
    chk[6] = ($countones(req.dbg) % 2) == 0;
    chk[5] = ($countones({req.be, req.we}) % 2) == 0;
    chk[4] = ($countones({req.prot, req.memtype}) % 2) == 0;
    return chk;
  endfunction

  function automatic logic [RCHK_W-1:0] expected_rchk(input logic [DATA_W-1:0] rdata,
                                                      input logic err);
    logic [RCHK_W-1:0] chk;
    // The exokay input is tied to zero, so bit 4 is err itself
    chk[4] = err;
    for (int i = 0; i < 4; i++) begin
      chk[i] = ($countones(rdata[8*i +: 8]) % 2) == 1;
    end
    return chk;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %0h actual %0h at cycle %0d", name, expected, actual, cycle);
      error_count++;
    end
  endtask

  task automatic drive_inputs();
    txn_info_t         head;
    logic [RCHK_W-1:0] flip;
    logic              mismatch;
    head     = '0;
    mismatch = 1'b0;
    if (req_done) begin
      core_req_valid = 1'b0;
      req_done       = 1'b0;
    end
    if (!core_req_valid && reqs_left > 0 && chance(2)) begin
      core_req_valid = 1'b1;
      core_req       = random_request();
      req_wait       = 0;
    end
    obi_gnt    = obi_req && chance(2);
    obi_gntpar = chance(12) ? obi_gnt : ~obi_gnt;
    cur_rvalid = 1'b0;
    cur_store  = 1'b0;
    cur_resp   = '0;
    obi_resp.rdata = next_random();
    obi_resp.err   = chance(8);
    obi_resp.rchk  = expected_rchk(obi_resp.rdata, obi_resp.err);
    // Responses leave in grant order, at least one cycle after their grant
    if (pend_q.size() > 0 && pend_ready_q[0] <= cycle && !chance(4)) begin
      head = pend_q.pop_front();
      pend_ready_q.delete(0);
      flip          = chance(4) ? RCHK_W'(next_random() % 31 + 1) : '0;
      obi_resp.rchk = obi_resp.rchk ^ flip;
      cur_rvalid    = 1'b1;
      cur_store     = head.is_store;
      mismatch      = head.is_store ? flip[RCHK_W-1] : (flip != '0);
    end
    obi_rvalid    = cur_rvalid;
    obi_rvalidpar = chance(12) ? obi_rvalid : ~obi_rvalid;
    if (cur_rvalid) begin
      cur_resp.rdata         = obi_resp.rdata;
      cur_resp.err           = obi_resp.err;
      cur_resp.integrity_err = (head.had_integrity && mismatch) ||
                               (obi_rvalidpar == obi_rvalid) || head.gnt_parity_err;
    end
    cfg_we           = cfg_pending;
    cfg_integrity_en = cfg_value;
    cfg_pending      = 1'b0;
  endtask

  task automatic sample_outputs();
    obi_req_t  exp_req;
    txn_info_t info;
    logic      exp_ready;
    exp_ready = (acc_q.size() == 0) && (pend_q.size() + int'(cur_rvalid) < DEPTH);
    check_value("ready", 128'(exp_ready), 128'(core_req_ready));
    check_value("req", 128'(acc_q.size() != 0), 128'(obi_req));
    check_value("reqpar", 128'(acc_q.size() == 0), 128'(obi_reqpar));
    check_value("resp_valid", 128'(exp_valid), 128'(core_resp_valid));
    if (exp_valid) begin
      check_value("resp", 128'(exp_resp), 128'(core_resp));
      if (exp_resp.integrity_err) faults_seen++;
    end
    check_value("alert", 128'(exp_alert), 128'(alert_major));
    check_value("fault_cause", 128'(model_cause), 128'(fault_cause));
    if (cfg_we) begin
      model_cause = FAULT_NONE;
    end else if (exp_valid && exp_resp.integrity_err && model_cause == FAULT_NONE) begin
      model_cause = exp_store ? FAULT_STORE : FAULT_LOAD;
    end
    if (obi_req && obi_gnt && acc_q.size() != 0) begin
      exp_req = acc_q.pop_front();
      check_value("payload", 128'(exp_req), 128'(obi_req_payload));
      check_value("achk", 128'(expected_achk(exp_req)), 128'(obi_achk));
      info.is_store       = exp_req.we;
      info.had_integrity  = model_en;
      info.gnt_parity_err = (obi_gnt == obi_gntpar);
      pend_q.push_back(info);
      pend_ready_q.push_back(cycle + 1 + int'(next_random() % 4));
    end
    if (core_req_valid && exp_ready && !req_done) begin
      acc_q.push_back(core_req);
      reqs_left--;
      req_done = 1'b1;
    end else if (core_req_valid && !req_done) begin
      req_wait++;
    end
    exp_alert = (obi_gnt == obi_gntpar) || (obi_rvalid == obi_rvalidpar) ||
                (cur_rvalid && cur_resp.integrity_err);
    exp_valid = cur_rvalid;
    exp_resp  = cur_resp;
    exp_store = cur_store;
    if (cfg_we) model_en = cfg_integrity_en;
    cycle++;
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #1;
    drive_inputs();
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic run_phase(input int count);
    int waited;
    waited    = 0;
    reqs_left = count;
    while (timeouts == 0 && (reqs_left > 0 || core_req_valid || acc_q.size() != 0 ||
           pend_q.size() != 0 || exp_valid)) begin
      run_cycle();
      waited++;
      if (waited > PHASE_LIMIT) begin
        $display("Timeout: bus traffic did not finish within %0d cycles", PHASE_LIMIT);
        timeouts++;
      end else if (req_wait > REQ_WAIT_LIMIT) begin
        $display("Timeout: a core request was never accepted");
        timeouts++;
      end
    end
  endtask

  task automatic write_config(input logic enable);
    cfg_pending = 1'b1;
    cfg_value   = enable;
    run_cycle();
  endtask

  initial begin
    lcg_state   = 32'h5cea_f9a8;
    cycle       = 0;
    reqs_left   = 0;
    req_wait    = 0;
    error_count = 0;
    timeouts    = 0;
    faults_seen = 0;
    req_done    = 1'b0;
    cfg_pending = 1'b0;
    cur_rvalid  = 1'b0;
    cur_store   = 1'b0;
    exp_valid   = 1'b0;
    exp_store   = 1'b0;
    exp_alert   = 1'b0;
    cfg_value   = 1'b1;
    model_en    = 1'b1;
    model_cause = FAULT_NONE;
    cur_resp    = '0;
    exp_resp    = '0;
    clk              = 1'b0;
    reset            = 1'b1;
    core_req_valid   = 1'b0;
    core_req         = '0;
    obi_gnt          = 1'b0;
    obi_gntpar       = 1'b1;
    obi_rvalid       = 1'b0;
    obi_rvalidpar    = 1'b1;
    obi_resp         = '0;
    cfg_we           = 1'b0;
    cfg_integrity_en = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("reset req", 128'(1'b0), 128'(obi_req));
    check_value("reset reqpar", 128'(1'b1), 128'(obi_reqpar));
    check_value("reset ready", 128'(1'b1), 128'(core_req_ready));
    check_value("reset resp_valid", 128'(1'b0), 128'(core_resp_valid));
    check_value("reset alert", 128'(1'b0), 128'(alert_major));
    check_value("reset fault_cause", 128'(FAULT_NONE), 128'(fault_cause));
    run_phase(150);
    write_config(1'b0);
    run_phase(100);
    write_config(1'b1);
    run_phase(60);
    if (faults_seen == 0) begin
      $display("No response with an integrity error was produced by the stimulus");
      error_count++;
    end
    $display("Checks done: %0d value errors, %0d assertion failures, %0d timeouts",
             error_count, dut0.u_asserts.fail_count, timeouts);
    if (error_count == 0 && dut0.u_asserts.fail_count == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
